// File: design/pio_pkg.sv
`default_nettype none

package pio_pkg;

	// bus widths
	localparam int ADDR_W = 14; // pio word address
	localparam int DATA_W = 32;
	localparam int BE_W   = 8;  // only low 4 bits carry lanes
	localparam int OFS_W  = 6;  // register offset inside region 01

	// region codes on address bits 13:12
	localparam logic [1:0] REGION_NONE = 2'b00; // unmapped, reads zero
	localparam logic [1:0] REGION_REGS = 2'b01; // network config registers
	localparam logic [1:0] REGION_BAR2 = 2'b10; // reserved window
	localparam logic [1:0] REGION_ROM  = 2'b11; // option rom

	// register offsets
	localparam logic [OFS_W-1:0] OFS_IF_V4      = 6'h00;
	localparam logic [OFS_W-1:0] OFS_IF_MAC_HI  = 6'h02; // mac 47:16
	localparam logic [OFS_W-1:0] OFS_IF_MAC_LO  = 6'h03; // mac 15:0
	localparam logic [OFS_W-1:0] OFS_DST_V4     = 6'h04;
	localparam logic [OFS_W-1:0] OFS_DST_MAC_HI = 6'h06;
	localparam logic [OFS_W-1:0] OFS_DST_MAC_LO = 6'h07;

	// register reset values
	localparam logic [31:0] RST_IF_V4   = 32'hd000_0000;
	localparam logic [47:0] RST_IF_MAC  = 48'h0037_7600_0001;
	localparam logic [31:0] RST_DST_V4  = 32'h0a00_15ff; // 10.0.21.255
	localparam logic [47:0] RST_DST_MAC = 48'hffff_ffff_ffff; // broadcast

endpackage

`default_nettype wire

// File: design/reg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

	logic [pio_pkg::OFS_W-1:0]  rd_ofs;  // sampled every cycle
	logic [pio_pkg::DATA_W-1:0] rd_data; // valid one cycle after rd_ofs
	logic [pio_pkg::OFS_W-1:0]  wr_ofs;
	logic [pio_pkg::BE_W-1:0]   wr_be;
	logic [pio_pkg::DATA_W-1:0] wr_data;
	logic                       wr_en;   // single-cycle strobe per word

	modport ctrl (
		output rd_ofs, wr_ofs, wr_be, wr_data, wr_en,
		input  rd_data
	);

	modport regs (
		input  rd_ofs, wr_ofs, wr_be, wr_data, wr_en,
		output rd_data
	);

endinterface

`default_nettype wire

// File: design/net_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module net_cfg_regs (
	input  logic              clk,
	input  logic              sys_rst,
	reg_access_if.regs        bus,
	input  logic [7:0]        debug,
	output logic [31:0]       if_v4addr,
	output logic [47:0]       if_macaddr,
	output logic [31:0]       dest_v4addr,
	output logic [47:0]       dest_macaddr
);

	// Byte-lane merge. Lane 0 is the most significant byte of the word,
	// so wr_be[0] selects bits 31:24 and wr_be[3] selects bits 7:0.
	function automatic logic [31:0] merge_lanes(
		input logic [31:0] old_word,
		input logic [31:0] new_word,
		input logic [3:0]  be
	);
		logic [31:0] word;
		word = old_word;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				word[31-8*i -: 8] = new_word[31-8*i -: 8];
		end
		return word;
	endfunction

	logic [31:0] if_mac_lo_wr;  // mac low half sits in the top 16 bits
	logic [31:0] dst_mac_lo_wr;

	// only lanes 0 and 1 exist at the mac low offsets
	assign if_mac_lo_wr = merge_lanes({if_macaddr[15:0], 16'h0000}, bus.wr_data,
		{2'b00, bus.wr_be[1:0]});
	assign dst_mac_lo_wr = merge_lanes({dest_macaddr[15:0], 16'h0000}, bus.wr_data,
		{2'b00, bus.wr_be[1:0]});

	always_ff @(posedge clk) begin
		if (sys_rst) begin
			if_v4addr    <= pio_pkg::RST_IF_V4;
			if_macaddr   <= pio_pkg::RST_IF_MAC;
			dest_v4addr  <= pio_pkg::RST_DST_V4;
			dest_macaddr <= pio_pkg::RST_DST_MAC;
		end else if (bus.wr_en) begin
			case (bus.wr_ofs)
				pio_pkg::OFS_IF_V4:
					if_v4addr <= merge_lanes(if_v4addr, bus.wr_data, bus.wr_be[3:0]);
				pio_pkg::OFS_IF_MAC_HI:
					if_macaddr[47:16] <= merge_lanes(if_macaddr[47:16], bus.wr_data,
						bus.wr_be[3:0]);
				pio_pkg::OFS_IF_MAC_LO:
					if_macaddr[15:0] <= if_mac_lo_wr[31:16];
				pio_pkg::OFS_DST_V4:
					dest_v4addr <= merge_lanes(dest_v4addr, bus.wr_data, bus.wr_be[3:0]);
				pio_pkg::OFS_DST_MAC_HI:
					dest_macaddr[47:16] <= merge_lanes(dest_macaddr[47:16], bus.wr_data,
						bus.wr_be[3:0]);
				pio_pkg::OFS_DST_MAC_LO:
					dest_macaddr[15:0] <= dst_mac_lo_wr[31:16];
				default: ; // undefined offsets ignore writes
			endcase
		end
	end

	// readback, one cycle after the offset
	always_ff @(posedge clk) begin
		if (sys_rst) begin
			bus.rd_data <= '0;
		end else begin
			case (bus.rd_ofs)
				pio_pkg::OFS_IF_V4:
					bus.rd_data <= if_v4addr;
				pio_pkg::OFS_IF_MAC_HI:
					bus.rd_data <= if_macaddr[47:16];
				pio_pkg::OFS_IF_MAC_LO:
					bus.rd_data <= {if_macaddr[15:0], 8'h00, debug}; // debug in low byte
				pio_pkg::OFS_DST_V4:
					bus.rd_data <= dest_v4addr;
				pio_pkg::OFS_DST_MAC_HI:
					bus.rd_data <= dest_macaddr[47:16];
				pio_pkg::OFS_DST_MAC_LO:
					bus.rd_data <= {dest_macaddr[15:0], 16'h0000};
				default:
					bus.rd_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/option_rom.sv
`timescale 1ns/1ps
`default_nettype none

module option_rom #(
	parameter int ROM_ADDR_W = 12
) (
	input  logic                       clk,
	input  logic [ROM_ADDR_W-1:0]      addr,
	output logic [pio_pkg::DATA_W-1:0] data
);

	localparam int DEPTH = 2 ** ROM_ADDR_W;

	logic [pio_pkg::DATA_W-1:0] mem [0:DEPTH-1];

	// words past the end of the hex file stay zero
	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
		$readmemh("design/option_rom.hex", mem);
	end

	// registered read, one cycle
	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

endmodule

`default_nettype wire

// File: design/pio_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module pio_mem_access #(
	parameter int ROM_ADDR_W = 12
) (
	input  logic                       clk,
	input  logic                       sys_rst,
	input  logic [pio_pkg::ADDR_W-1:0] rd_addr,
	input  logic [pio_pkg::ADDR_W-1:0] wr_addr,
	input  logic [pio_pkg::BE_W-1:0]   wr_be,
	input  logic [pio_pkg::DATA_W-1:0] wr_data,
	input  logic                       wr_en,
	output logic [pio_pkg::DATA_W-1:0] rd_data,
	reg_access_if.ctrl                 bus
);

	logic [1:0]                 rd_region_q; // region of the word in flight
	logic [pio_pkg::DATA_W-1:0] rom_data;

	// offsets go straight to the register block
	assign bus.rd_ofs  = rd_addr[pio_pkg::OFS_W-1:0];
	assign bus.wr_ofs  = wr_addr[pio_pkg::OFS_W-1:0];
	assign bus.wr_be   = wr_be;
	assign bus.wr_data = wr_data;
	// writes outside region 01 are dropped here
	assign bus.wr_en   = wr_en && (wr_addr[13:12] == pio_pkg::REGION_REGS);

	option_rom #(
		.ROM_ADDR_W (ROM_ADDR_W)
	) u_rom (
		.clk  (clk),
		.addr (rd_addr[ROM_ADDR_W-1:0]),
		.data (rom_data)
	);

	// region follows the data through the same register stage
	always_ff @(posedge clk) begin
		if (sys_rst)
			rd_region_q <= pio_pkg::REGION_NONE; // selects zero after reset
		else
			rd_region_q <= rd_addr[13:12];
	end

	always_comb begin
		case (rd_region_q)
			pio_pkg::REGION_REGS: rd_data = bus.rd_data;
			pio_pkg::REGION_ROM:  rd_data = rom_data;
			default:              rd_data = '0; // unmapped and bar2
		endcase
	end

endmodule

`default_nettype wire

// File: design/pio_ep_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module pio_ep_mem_top #(
	parameter int ROM_ADDR_W = 12 // rom holds 2**ROM_ADDR_W words
) (
	input  logic                       clk,
	input  logic                       sys_rst,
	input  logic [pio_pkg::ADDR_W-1:0] rd_addr,
	output logic [pio_pkg::DATA_W-1:0] rd_data,
	input  logic [pio_pkg::ADDR_W-1:0] wr_addr,
	input  logic [pio_pkg::BE_W-1:0]   wr_be,
	input  logic [pio_pkg::DATA_W-1:0] wr_data,
	input  logic                       wr_en,
	input  logic [7:0]                 debug,
	output logic [31:0]                if_v4addr,
	output logic [47:0]                if_macaddr,
	output logic [31:0]                dest_v4addr,
	output logic [47:0]                dest_macaddr
);

	reg_access_if reg_bus ();

	pio_mem_access #(
		.ROM_ADDR_W (ROM_ADDR_W)
	) u_access (
		.clk     (clk),
		.sys_rst (sys_rst),
		.rd_addr (rd_addr),
		.wr_addr (wr_addr),
		.wr_be   (wr_be),
		.wr_data (wr_data),
		.wr_en   (wr_en),
		.rd_data (rd_data),
		.bus     (reg_bus.ctrl)
	);

	net_cfg_regs u_regs (
		.clk          (clk),
		.sys_rst      (sys_rst),
		.bus          (reg_bus.regs),
		.debug        (debug),
		.if_v4addr    (if_v4addr),
		.if_macaddr   (if_macaddr),
		.dest_v4addr  (dest_v4addr),
		.dest_macaddr (dest_macaddr)
	);

endmodule

`default_nettype wire

// File: sim/tb_pio_ep_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pio_ep_mem;

	localparam int         CLK_PERIOD  = 100;
	localparam int         RST_CYCLES  = 5;
	localparam int         MAX_ENTRIES = 128;
	localparam logic [7:0] DEBUG_BYTE  = 8'h5c;
	localparam bit         OP_WR       = 1'b1;
	localparam bit         OP_RD       = 1'b0;

	logic        clk;
	logic        sys_rst;
	logic [13:0] rd_addr;
	logic [31:0] rd_data;
	logic [13:0] wr_addr;
	logic [7:0]  wr_be;
	logic [31:0] wr_data;
	logic        wr_en;
	logic [7:0]  debug;
	logic [31:0] if_v4addr;
	logic [47:0] if_macaddr;
	logic [31:0] dest_v4addr;
	logic [47:0] dest_macaddr;

	string       tbl_name    [0:MAX_ENTRIES-1];
	bit          tbl_op      [0:MAX_ENTRIES-1];
	logic [13:0] tbl_addr    [0:MAX_ENTRIES-1];
	logic [7:0]  tbl_be      [0:MAX_ENTRIES-1];
	logic [31:0] tbl_data    [0:MAX_ENTRIES-1];
	logic [31:0] tbl_exp     [0:MAX_ENTRIES-1]; // expected rd_data of a read
	logic [31:0] tbl_if_v4   [0:MAX_ENTRIES-1]; // register outputs after the entry
	logic [47:0] tbl_if_mac  [0:MAX_ENTRIES-1];
	logic [31:0] tbl_dst_v4  [0:MAX_ENTRIES-1];
	logic [47:0] tbl_dst_mac [0:MAX_ENTRIES-1];
	int          n_entries;
	bit          table_ready;

	logic [31:0] m_if_v4; // reference model of the registers
	logic [47:0] m_if_mac;
	logic [31:0] m_dst_v4;
	logic [47:0] m_dst_mac;
	logic [31:0] rom_ref [0:4095];

	int          error_count;
	int          check_count;
	int unsigned seed;

	pio_ep_mem_top #(
		.ROM_ADDR_W (12)
	) dut (
		.clk          (clk),
		.sys_rst      (sys_rst),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.wr_addr      (wr_addr),
		.wr_be        (wr_be),
		.wr_data      (wr_data),
		.wr_en        (wr_en),
		.debug        (debug),
		.if_v4addr    (if_v4addr),
		.if_macaddr   (if_macaddr),
		.dest_v4addr  (dest_v4addr),
		.dest_macaddr (dest_macaddr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [47:0] expected,
		input logic [47:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] lane_mask(input logic [3:0] be);
		return {{8{be[0]}}, {8{be[1]}}, {8{be[2]}}, {8{be[3]}}}; // lane 0 is bits 31:24
	endfunction

	function automatic logic [13:0] reg_addr(input logic [5:0] ofs);
		return {2'b01, 6'b000000, ofs};
	endfunction

	function automatic logic [5:0] reg_ofs(input int k);
		case (k)
			0:       return pio_pkg::OFS_IF_V4;
			1:       return pio_pkg::OFS_IF_MAC_HI;
			2:       return pio_pkg::OFS_IF_MAC_LO;
			3:       return pio_pkg::OFS_DST_V4;
			4:       return pio_pkg::OFS_DST_MAC_HI;
			default: return pio_pkg::OFS_DST_MAC_LO;
		endcase
	endfunction

	task automatic model_write(input logic [13:0] addr, input logic [7:0] be,
		input logic [31:0] data);
		logic [31:0] mask;
		logic [15:0] lo_mask;
		mask    = lane_mask(be[3:0]);
		lo_mask = mask[31:16]; // mac low word has lanes 0 and 1
		if (addr[13:12] == pio_pkg::REGION_REGS) begin
			case (addr[5:0])
				pio_pkg::OFS_IF_V4:      m_if_v4 = (m_if_v4 & ~mask) | (data & mask);
				pio_pkg::OFS_IF_MAC_HI:  m_if_mac[47:16] = (m_if_mac[47:16] & ~mask) | (data & mask);
				pio_pkg::OFS_IF_MAC_LO:  m_if_mac[15:0] = (m_if_mac[15:0] & ~lo_mask)
					| (data[31:16] & lo_mask);
				pio_pkg::OFS_DST_V4:     m_dst_v4 = (m_dst_v4 & ~mask) | (data & mask);
				pio_pkg::OFS_DST_MAC_HI: m_dst_mac[47:16] = (m_dst_mac[47:16] & ~mask)
					| (data & mask);
				pio_pkg::OFS_DST_MAC_LO: m_dst_mac[15:0] = (m_dst_mac[15:0] & ~lo_mask)
					| (data[31:16] & lo_mask);
				default: ;
			endcase
		end
	endtask

	function automatic logic [31:0] model_read(input logic [13:0] addr);
		logic [31:0] word;
		word = '0; // unmapped, bar2 and undefined offsets
		if (addr[13:12] == pio_pkg::REGION_ROM) begin
			word = rom_ref[addr[11:0]];
		end else if (addr[13:12] == pio_pkg::REGION_REGS) begin
			case (addr[5:0])
				pio_pkg::OFS_IF_V4:      word = m_if_v4;
				pio_pkg::OFS_IF_MAC_HI:  word = m_if_mac[47:16];
				pio_pkg::OFS_IF_MAC_LO:  word = {m_if_mac[15:0], 8'h00, DEBUG_BYTE};
				pio_pkg::OFS_DST_V4:     word = m_dst_v4;
				pio_pkg::OFS_DST_MAC_HI: word = m_dst_mac[47:16];
				pio_pkg::OFS_DST_MAC_LO: word = {m_dst_mac[15:0], 16'h0000};
				default:                 word = '0;
			endcase
		end
		return word;
	endfunction

	task automatic add_entry(input string name, input bit op, input logic [13:0] addr,
		input logic [7:0] be, input logic [31:0] data);
		int k;
		k = n_entries;
		tbl_name[k] = $sformatf("%s@%h", name, addr);
		tbl_op[k]   = op;
		tbl_addr[k] = addr;
		tbl_be[k]   = be;
		tbl_data[k] = data;
		tbl_exp[k]  = '0;
		if (op == OP_WR)
			model_write(addr, be, data);
		else
			tbl_exp[k] = model_read(addr);
		tbl_if_v4[k]   = m_if_v4;
		tbl_if_mac[k]  = m_if_mac;
		tbl_dst_v4[k]  = m_dst_v4;
		tbl_dst_mac[k] = m_dst_mac;
		n_entries++;
	endtask

	task automatic add_reg_reads(input string name);
		for (int k = 0; k < 6; k++)
			add_entry(name, OP_RD, reg_addr(reg_ofs(k)), 8'h00, 32'h0);
	endtask

	task automatic build_table();
		m_if_v4   = pio_pkg::RST_IF_V4;
		m_if_mac  = pio_pkg::RST_IF_MAC;
		m_dst_v4  = pio_pkg::RST_DST_V4;
		m_dst_mac = pio_pkg::RST_DST_MAC;
		n_entries = 0;
		add_reg_reads("reset_read");
		for (int k = 0; k < 6; k++)
			add_entry("full_write", OP_WR, reg_addr(reg_ofs(k)), 8'h0f, $urandom());
		add_reg_reads("full_read");
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_IF_V4), 8'h01, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_DST_V4), 8'h08, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_IF_MAC_HI), 8'h06, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_DST_MAC_HI), 8'h09, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_IF_MAC_LO), 8'h02, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_DST_MAC_LO), 8'h0c, $urandom());
		add_entry("part_write", OP_WR, reg_addr(pio_pkg::OFS_DST_MAC_LO), 8'h01, $urandom());
		add_reg_reads("part_read");
		add_entry("foreign_write", OP_WR, 14'h0000, 8'h0f, $urandom());
		add_entry("foreign_write", OP_WR, 14'h2004, 8'h0f, $urandom());
		add_entry("foreign_write", OP_WR, 14'h3002, 8'hff, $urandom());
		add_entry("foreign_write", OP_WR, 14'h3007, 8'h0f, $urandom());
		add_reg_reads("foreign_read");
		for (int k = 0; k < 32; k++)
			add_entry("rom_read", OP_RD, {2'b11, 12'(k)}, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h3020, 8'h00, 32'h0); // past the rom image
		add_entry("zero_read", OP_RD, 14'h3fff, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h0000, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h0003, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h2000, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h2006, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h1001, 8'h00, 32'h0); // undefined offsets
		add_entry("zero_read", OP_RD, 14'h1005, 8'h00, 32'h0);
		add_entry("zero_read", OP_RD, 14'h103f, 8'h00, 32'h0);
		add_entry("mixed_read", OP_RD, 14'h3005, 8'h00, 32'h0); // region changes every cycle
		add_entry("mixed_read", OP_RD, 14'h1003, 8'h00, 32'h0);
		add_entry("mixed_read", OP_RD, 14'h3006, 8'h00, 32'h0);
		add_entry("mixed_read", OP_RD, 14'h2003, 8'h00, 32'h0);
		add_entry("mixed_read", OP_RD, 14'h1007, 8'h00, 32'h0);
	endtask

	task automatic drive_entry(input int k);
		wr_en   = (tbl_op[k] == OP_WR);
		wr_addr = tbl_addr[k];
		wr_be   = tbl_be[k];
		wr_data = tbl_data[k];
		rd_addr = (tbl_op[k] == OP_RD) ? tbl_addr[k] : 14'h0000;
	endtask

	task automatic check_entry(input int k);
		check_value({tbl_name[k], " if_v4addr"}, {16'h0, tbl_if_v4[k]}, {16'h0, if_v4addr});
		check_value({tbl_name[k], " if_macaddr"}, tbl_if_mac[k], if_macaddr);
		check_value({tbl_name[k], " dest_v4addr"}, {16'h0, tbl_dst_v4[k]}, {16'h0, dest_v4addr});
		check_value({tbl_name[k], " dest_macaddr"}, tbl_dst_mac[k], dest_macaddr);
		if (tbl_op[k] == OP_RD)
			check_value({tbl_name[k], " rd_data"}, {16'h0, tbl_exp[k]}, {16'h0, rd_data});
	endtask

	// watchdog allows three cycles per table entry plus reset
	initial begin
		wait (table_ready);
		repeat (n_entries * 3 + RST_CYCLES + 4) @(posedge clk);
		$display("timeout: the stimulus table did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		clk         = 1'b0;
		sys_rst     = 1'b1;
		rd_addr     = 14'h3000; // rom word 0 reads nonzero
		wr_addr     = '0;
		wr_be       = '0;
		wr_data     = '0;
		wr_en       = 1'b0;
		debug       = DEBUG_BYTE;
		error_count = 0;
		check_count = 0;
		table_ready = 1'b0;
		seed        = $urandom(97);
		for (int i = 0; i < 4096; i++)
			rom_ref[i] = '0;
		$readmemh("design/option_rom.hex", rom_ref);
		build_table();
		table_ready = 1'b1;

		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		sys_rst = 1'b0;
		check_value("reset rd_data", 48'h0, {16'h0, rd_data});
		check_value("reset if_v4addr", {16'h0, pio_pkg::RST_IF_V4}, {16'h0, if_v4addr});
		check_value("reset if_macaddr", pio_pkg::RST_IF_MAC, if_macaddr);
		check_value("reset dest_v4addr", {16'h0, pio_pkg::RST_DST_V4}, {16'h0, dest_v4addr});
		check_value("reset dest_macaddr", pio_pkg::RST_DST_MAC, dest_macaddr);

		// one entry per cycle and its check on the next falling edge
		for (int i = 0; i <= n_entries; i++) begin
			if (i > 0)
				check_entry(i - 1);
			if (i < n_entries)
				drive_entry(i);
			else
				wr_en = 1'b0;
			@(negedge clk);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/option_rom.hex
// option rom image, one 32-bit hex word per line starting at word 0
0055aa40
52494350
0000001c
00008086
10d30000
00180000
00010002
80000000
13572468
2468ace0
fedcba98
76543210
0f1e2d3c
4b5a6978
8796a5b4
c3d2e1f0
deadbe01
cafe0002
0badf00d
11223344
55667788
99aabbcc
ddeeff00
a5a5005a
5a5aa5a5
01234567
89abcdef
13579bdf
2468ace1
fffe0001
7ffffffe
c0ffee10

// File: src.f
design/pio_pkg.sv
design/reg_access_if.sv
design/net_cfg_regs.sv
design/option_rom.sv
design/pio_mem_access.sv
design/pio_ep_mem_top.sv
sim/tb_pio_ep_mem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_pio_ep_mem
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
